// File: src/drumPkg.sv
package drumPkg;

  // Grid geometry
  localparam int GridSize = 4;
  localparam int coordW   = 2;

  // Fixed point format, 1.17 signed
  localparam int FracBits = 17;

  typedef logic signed [17:0] sample_t;

  // Largest value below 1.0, stands in for one in (1 - eta)
  localparam sample_t OneFixed = 18'sh1ffff;

  // Wave coefficient rho per tension setting, all below 0.25
  localparam sample_t tensionTable [0:7] = '{
    18'sd2621,   // 0.02
    18'sd5243,   // 0.04
    18'sd7864,   // 0.06
    18'sd10486,  // 0.08
    18'sd13107,  // 0.10
    18'sd16384,  // 0.125
    18'sd19661,  // 0.15
    18'sd26214   // 0.20
  };

  typedef enum logic [1:0] {
    phIdle = 2'd0,
    phMul0 = 2'd1,
    phMul1 = 2'd2,
    phMul2 = 2'd3
  } phase_t;

  typedef struct packed {
    sample_t    eta;
    logic [2:0] tensionSel;
  } stepCmd_t;

  typedef struct packed {
    logic [coordW-1:0] strikeX;
    logic [coordW-1:0] strikeY;
    logic [coordW-1:0] listenX;
    logic [coordW-1:0] listenY;
    sample_t           amplitude;
  } strikeCmd_t;

  // Broadcast to every node of the grid
  typedef struct packed {
    phase_t            phase;
    sample_t           rho;
    sample_t           oneMinusEta;
    logic              clear;
    logic              strike;
    logic [coordW-1:0] strikeX;
    logic [coordW-1:0] strikeY;
    sample_t           amplitude;
  } nodeCtrl_t;

  // Full signed product, arithmetic shift by FracBits, truncate to 18 bits
  function automatic sample_t fixMul(input sample_t a, input sample_t b);
    logic signed [35:0] prod;
    prod = a * b;
    return sample_t'(prod >>> FracBits);
  endfunction

endpackage

// File: src/drumNode.sv
module drumNode (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [drumPkg::coordW-1:0] xId,
  input  logic [drumPkg::coordW-1:0] yId,
  input  drumPkg::nodeCtrl_t        ctrl,
  input  drumPkg::sample_t          uNorth,
  input  drumPkg::sample_t          uSouth,
  input  drumPkg::sample_t          uEast,
  input  drumPkg::sample_t          uWest,
  output drumPkg::sample_t          u
);

  import drumPkg::*;

  // Discrete Laplacian around this point
  sample_t lap;

  // Previous displacement and partial products
  sample_t uPrev;
  sample_t p0;
  sample_t p1;

  // Shared multiplier operands and result
  sample_t mulA;
  sample_t mulB;
  sample_t mulOut;

  logic isStruck;

  // Sums wrap at 18 bits
  assign lap = uNorth + uSouth + uEast + uWest - (u <<< 2);

  assign isStruck = (xId == ctrl.strikeX) && (yId == ctrl.strikeY);

  // Operand select per phase
  always_comb
  begin
    case (ctrl.phase)
      phMul0:
      begin
        mulA = ctrl.rho;
        mulB = lap;
      end
      phMul1:
      begin
        mulA = ctrl.oneMinusEta;
        mulB = p0;
      end
      default:
      begin
        // phMul2, also harmless while idle
        mulA = ctrl.oneMinusEta;
        mulB = uPrev;
      end
    endcase
  end

  // The one multiplier of this node
  assign mulOut = fixMul(mulA, mulB);

  // Intermediate products, only meaningful inside a step
  always_ff @(posedge clk)
  begin
    if (ctrl.phase == phMul0)
    begin
      p0 <= mulOut;
    end
    if (ctrl.phase == phMul1)
    begin
      p1 <= mulOut;
    end
  end

  // Membrane state
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      u     <= '0;
      uPrev <= '0;
    end
    else if (ctrl.clear)
    begin
      // Strike: flat membrane except the struck point
      uPrev <= '0;
      if (ctrl.strike && isStruck)
      begin
        u <= ctrl.amplitude;
      end
      else
      begin
        u <= '0;
      end
    end
    else if (ctrl.phase == phMul2)
    begin
      // u' = (1-eta)*rho*lap + 2u - (1-eta)*uPrev
      uPrev <= u;
      u     <= p1 + (u <<< 1) - mulOut;
    end
  end

endmodule

// File: src/stepSequencer.sv
module stepSequencer (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       stepValid,
  input  drumPkg::stepCmd_t          step,
  input  logic                       strikeValid,
  input  drumPkg::strikeCmd_t        strike,
  output drumPkg::nodeCtrl_t         ctrl,
  output logic [drumPkg::coordW-1:0] listenX,
  output logic [drumPkg::coordW-1:0] listenY,
  output logic                       sampleValid,
  output logic                       busy
);

  import drumPkg::*;

  phase_t            phase;
  sample_t           rhoReg;
  sample_t           oneMinusEtaReg;
  logic              strikePulse;
  logic [coordW-1:0] strikeXReg;
  logic [coordW-1:0] strikeYReg;
  sample_t           amplitudeReg;

  logic acceptStep;
  logic acceptStrike;

  // Strike wins over a simultaneous step
  assign acceptStrike = strikeValid && !busy;
  assign acceptStep   = stepValid && !busy && !strikeValid;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      phase          <= phIdle;
      rhoReg         <= '0;
      oneMinusEtaReg <= '0;
      strikePulse    <= 1'b0;
      strikeXReg     <= '0;
      strikeYReg     <= '0;
      listenX        <= '0;
      listenY        <= '0;
      sampleValid    <= 1'b0;
      busy           <= 1'b0;
    end
    else
    begin
      strikePulse <= acceptStrike;
      sampleValid <= (phase == phMul2);

      case (phase)
        phIdle: if (acceptStep) phase <= phMul0;
        phMul0: phase <= phMul1;
        phMul1: phase <= phMul2;
        default: phase <= phIdle;
      endcase

      if (acceptStep)
      begin
        rhoReg         <= tensionTable[step.tensionSel];
        oneMinusEtaReg <= OneFixed - step.eta;
      end

      if (acceptStrike)
      begin
        strikeXReg <= strike.strikeX;
        strikeYReg <= strike.strikeY;
        listenX    <= strike.listenX;
        listenY    <= strike.listenY;
      end

      // Busy ends after the sample cycle or the strike cycle
      if (acceptStep || acceptStrike)
      begin
        busy <= 1'b1;
      end
      else if (sampleValid || strikePulse)
      begin
        busy <= 1'b0;
      end
    end
  end

  // Strike amplitude for the load cycle
  always_ff @(posedge clk)
  begin
    if (acceptStrike)
    begin
      amplitudeReg <= strike.amplitude;
    end
  end

  always_comb
  begin
    ctrl.phase       = phase;
    ctrl.rho         = rhoReg;
    ctrl.oneMinusEta = oneMinusEtaReg;
    ctrl.clear       = strikePulse;
    ctrl.strike      = strikePulse;
    ctrl.strikeX     = strikeXReg;
    ctrl.strikeY     = strikeYReg;
    ctrl.amplitude   = amplitudeReg;
  end

endmodule

// File: src/drumGrid.sv
module drumGrid (
  input  logic                       clk,
  input  logic                       reset,
  input  drumPkg::nodeCtrl_t         ctrl,
  input  logic [drumPkg::coordW-1:0] listenX,
  input  logic [drumPkg::coordW-1:0] listenY,
  output drumPkg::sample_t           listenU
);

  import drumPkg::*;

  // Displacements with a ring of clamped zeros, indexed [y][x]
  // Node x,y sits at uPad[y+1][x+1]
  sample_t uPad [GridSize+2][GridSize+2];

  // Clamped edges
  for (genvar i = 0; i < GridSize + 2; i++)
  begin : gRowEdge
    assign uPad[0][i]          = '0;
    assign uPad[GridSize+1][i] = '0;
  end

  for (genvar i = 1; i <= GridSize; i++)
  begin : gColEdge
    assign uPad[i][0]          = '0;
    assign uPad[i][GridSize+1] = '0;
  end

  // North is smaller y, west is smaller x
  for (genvar gy = 0; gy < GridSize; gy++)
  begin : gRow
    for (genvar gx = 0; gx < GridSize; gx++)
    begin : gCol
      drumNode node (
        .clk    (clk),
        .reset  (reset),
        .xId    (coordW'(gx)),
        .yId    (coordW'(gy)),
        .ctrl   (ctrl),
        .uNorth (uPad[gy][gx+1]),
        .uSouth (uPad[gy+2][gx+1]),
        .uEast  (uPad[gy+1][gx+2]),
        .uWest  (uPad[gy+1][gx]),
        .u      (uPad[gy+1][gx+1])
      );
    end
  end

  // Listening point select
  always_comb
  begin
    listenU = uPad[int'(listenY) + 1][int'(listenX) + 1];
  end

endmodule

// File: src/drumTop.sv
module drumTop (
  input  logic                clk,
  input  logic                reset,
  input  logic                stepValid,
  input  drumPkg::stepCmd_t   step,
  input  logic                strikeValid,
  input  drumPkg::strikeCmd_t strike,
  output logic                sampleValid,
  output drumPkg::sample_t    sample,
  output logic                busy
);

  import drumPkg::*;

  nodeCtrl_t         ctrl;
  logic [coordW-1:0] listenX;
  logic [coordW-1:0] listenY;

  // Phase control and command capture
  stepSequencer sequencer (
    .clk         (clk),
    .reset       (reset),
    .stepValid   (stepValid),
    .step        (step),
    .strikeValid (strikeValid),
    .strike      (strike),
    .ctrl        (ctrl),
    .listenX     (listenX),
    .listenY     (listenY),
    .sampleValid (sampleValid),
    .busy        (busy)
  );

  // Membrane nodes
  drumGrid grid (
    .clk     (clk),
    .reset   (reset),
    .ctrl    (ctrl),
    .listenX (listenX),
    .listenY (listenY),
    .listenU (sample)
  );

endmodule

// File: tb/drumTop_props.sv
module drumTopProps (
  input logic clk,
  input logic reset,
  input logic stepValid,
  input logic strikeValid,
  input logic sampleValid,
  input logic busy
);

  timeunit 1ns;
  timeprecision 100ps;

  int failCount = 0;

  // Strike wins over a step in the same cycle
  logic acceptStep;
  assign acceptStep = stepValid && !busy && !strikeValid;

  samplePulse: assert property (@(posedge clk) disable iff (reset)
    sampleValid |=> !sampleValid)
  else
  begin
    $error("sampleValid stayed high for more than one cycle");
    failCount++;
  end

  stepLatency: assert property (@(posedge clk) disable iff (reset)
    acceptStep |=> !sampleValid [*3] ##1 sampleValid)
  else
  begin
    $error("sampleValid did not follow an accepted step by exactly 4 cycles");
    failCount++;
  end

  idleAfterReset: assert property (@(posedge clk)
    $fell(reset) |-> !busy)
  else
  begin
    $error("busy was high right after reset");
    failCount++;
  end

  sampleHasStep: assert property (@(posedge clk) disable iff (reset)
    $rose(sampleValid) |-> $past(acceptStep, 4))
  else
  begin
    $error("sampleValid rose without an accepted step 4 cycles earlier");
    failCount++;
  end

endmodule

bind drumTop drumTopProps props (
  .clk         (clk),
  .reset       (reset),
  .stepValid   (stepValid),
  .strikeValid (strikeValid),
  .sampleValid (sampleValid),
  .busy        (busy)
);

// File: tb/drumTb.sv
module drumTb;

  timeunit 1ns;
  timeprecision 100ps;

  import drumPkg::*;

  logic       clk;
  logic       reset;
  logic       stepValid;
  stepCmd_t   step;
  logic       strikeValid;
  strikeCmd_t strike;
  logic       sampleValid;
  sample_t    sample;
  logic       busy;

  int checks = 0;
  int errors = 0;

  // Expected samples still in flight
  sample_t expQ [$];
  string   nameQ [$];

  // Model membrane, indexed [y][x]
  sample_t mU [GridSize][GridSize];
  sample_t mPrev [GridSize][GridSize];
  int      mListenX;
  int      mListenY;

  logic [31:0] lfsrState = 32'h1a5163a9;

  drumTop dut (
    .clk         (clk),
    .reset       (reset),
    .stepValid   (stepValid),
    .step        (step),
    .strikeValid (strikeValid),
    .strike      (strike),
    .sampleValid (sampleValid),
    .sample      (sample),
    .busy        (busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsrBit()};
    end
    return v;
  endfunction

  // eta up to 1/16
  function automatic stepCmd_t pickStep();
    stepCmd_t c;
    c.eta        = sample_t'(takeBits(13));
    c.tensionSel = 3'(takeBits(3));
    return c;
  endfunction

  // Amplitude magnitude stays below 0.5
  function automatic strikeCmd_t drawStrike();
    strikeCmd_t s;
    s.strikeX   = coordW'(takeBits(2));
    s.strikeY   = coordW'(takeBits(2));
    s.listenX   = coordW'(takeBits(2));
    s.listenY   = coordW'(takeBits(2));
    s.amplitude = sample_t'(takeBits(16));
    if (takeBits(1))
    begin
      s.amplitude = -s.amplitude;
    end
    return s;
  endfunction

  // 1.17 product of two samples
  function automatic sample_t mulFix(input sample_t a, input sample_t b);
    logic signed [35:0] wa;
    logic signed [35:0] wb;
    logic signed [35:0] full;
    wa = a;
    wb = b;
    full = (wa * wb) >>> FracBits;
    return full[17:0];
  endfunction

  // Clamped rim reads as zero
  function automatic sample_t neighbourU(input int x, input int y);
    if (x < 0 || x >= GridSize || y < 0 || y >= GridSize)
    begin
      return '0;
    end
    return mU[y][x];
  endfunction

  function automatic void modelStrike(input strikeCmd_t s);
    for (int y = 0; y < GridSize; y++)
    begin
      for (int x = 0; x < GridSize; x++)
      begin
        mU[y][x]    = '0;
        mPrev[y][x] = '0;
      end
    end
    mU[s.strikeY][s.strikeX] = s.amplitude;
    mListenX = s.listenX;
    mListenY = s.listenY;
  endfunction

  // One time step of the whole membrane
  function automatic sample_t advanceModel(input stepCmd_t c);
    sample_t nu [GridSize][GridSize];
    sample_t rho;
    sample_t om;
    sample_t lap;
    rho = tensionTable[c.tensionSel];
    om  = OneFixed - c.eta;
    for (int y = 0; y < GridSize; y++)
    begin
      for (int x = 0; x < GridSize; x++)
      begin
        lap = sample_t'(neighbourU(x, y - 1) + neighbourU(x, y + 1) + neighbourU(x - 1, y)
            + neighbourU(x + 1, y) - 4 * mU[y][x]);
        nu[y][x] = sample_t'(mulFix(om, mulFix(rho, lap)) + 2 * mU[y][x]
                 - mulFix(om, mPrev[y][x]));
      end
    end
    mPrev = mU;
    mU    = nu;
    return mU[mListenY][mListenX];
  endfunction

  task automatic checkValue(input string name, input logic signed [31:0] expected,
                            input logic signed [31:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic awaitSample(input string name);
    int n;
    n = 0;
    while (expQ.size() != 0 && n < 20)
    begin
      @(posedge clk);
      n++;
    end
    if (expQ.size() != 0)
    begin
      errors++;
      $display("Error: no sampleValid within 20 cycles after step %s", name);
      expQ.delete();
      nameQ.delete();
    end
  endtask

  task automatic waitIdle();
    int n;
    n = 0;
    while (busy && n < 20)
    begin
      @(negedge clk);
      n++;
    end
    if (busy)
    begin
      errors++;
      $display("Error: busy stayed high for 20 cycles after a strike");
    end
  endtask

  // With pokeBusy set a step and a strike strobe arrive while busy
  task automatic issueStep(input string name, input stepCmd_t c, input bit pokeBusy);
    @(negedge clk);
    step      = c;
    stepValid = 1'b1;
    expQ.push_back(advanceModel(c));
    nameQ.push_back(name);
    @(negedge clk);
    stepValid = 1'b0;
    if (pokeBusy)
    begin
      checkValue({name, " busy"}, 1, busy);
      step      = pickStep();
      stepValid = 1'b1;
      @(negedge clk);
      stepValid   = 1'b0;
      strike      = drawStrike();
      strikeValid = 1'b1;
      @(negedge clk);
      strikeValid = 1'b0;
    end
    awaitSample(name);
  endtask

  task automatic sendStrike(input strikeCmd_t s);
    @(negedge clk);
    strike      = s;
    strikeValid = 1'b1;
    modelStrike(s);
    @(negedge clk);
    strikeValid = 1'b0;
    waitIdle();
  endtask

  // Outputs are sampled at the falling edge
  initial
  begin
    string   name;
    sample_t expected;
    forever
    begin
      @(negedge clk);
      if (!reset && sampleValid)
      begin
        if (expQ.size() == 0)
        begin
          errors++;
          $display("Error: sampleValid was high with no step outstanding");
        end
        else
        begin
          name     = nameQ.pop_front();
          expected = expQ.pop_front();
          checkValue(name, expected, sample);
        end
      end
    end
  end

  initial
  begin
    strikeCmd_t hit;
    stepCmd_t   cmd;
    sample_t    formula;
    bit [7:0]   seenSel;
    reset       = 1'b1;
    stepValid   = 1'b0;
    step        = '0;
    strikeValid = 1'b0;
    strike      = '0;
    seenSel     = '0;
    // All-zero strike is the flat membrane heard at 0,0
    modelStrike('0);
    repeat (5) @(negedge clk);
    reset = 1'b0;

    repeat (10)
    begin
      @(negedge clk);
      checkValue("idle sampleValid", 0, sampleValid);
      checkValue("idle busy", 0, busy);
    end
    issueStep("flat membrane", pickStep(), 1'b0);

    hit = '{strikeX: 1, strikeY: 1, listenX: 1, listenY: 1, amplitude: 18'sd65536};
    sendStrike(hit);
    for (int i = 0; i < 30; i++)
    begin
      cmd = pickStep();
      cmd.tensionSel = 3'd5;
      issueStep("centre strike", cmd, 1'b0);
    end

    hit = '{strikeX: 2, strikeY: 1, listenX: 2, listenY: 2, amplitude: 18'sd40000};
    sendStrike(hit);
    cmd = pickStep();
    formula = mulFix(OneFixed - cmd.eta, mulFix(tensionTable[cmd.tensionSel], hit.amplitude));
    issueStep("neighbour first step", cmd, 1'b0);
    @(negedge clk);
    checkValue("neighbour formula", formula, sample);
    repeat (8) issueStep("neighbour", pickStep(), 1'b0);

    // Strobes while busy
    for (int i = 0; i < 4; i++)
    begin
      issueStep("busy strobes", pickStep(), 1'b1);
    end
    repeat (4) issueStep("after busy strobes", pickStep(), 1'b0);

    hit = '{strikeX: 0, strikeY: 3, listenX: 0, listenY: 3, amplitude: -18'sd50000};
    sendStrike(hit);
    repeat (5) issueStep("before restrike", pickStep(), 1'b0);
    hit = '{strikeX: 3, strikeY: 0, listenX: 3, listenY: 1, amplitude: 18'sd30000};
    sendStrike(hit);
    repeat (4) issueStep("after restrike", pickStep(), 1'b0);

    sendStrike(drawStrike());
    for (int i = 0; i < 60; i++)
    begin
      if (takeBits(3) == 0)
      begin
        sendStrike(drawStrike());
      end
      else
      begin
        cmd = pickStep();
        seenSel[cmd.tensionSel] = 1'b1;
        issueStep("random", cmd, 1'b0);
      end
    end
    // Top up any tension entry the random run missed
    for (int s = 0; s < 8; s++)
    begin
      if (!seenSel[s])
      begin
        cmd = pickStep();
        cmd.tensionSel = 3'(s);
        issueStep("tension sweep", cmd, 1'b0);
      end
    end

    repeat (6) @(negedge clk);
    // Assertion failures of the bound checker
    errors += dut.props.failCount;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("=== PASS ===");
    end
    else
    begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: files.f
src/drumPkg.sv
src/drumNode.sv
src/stepSequencer.sv
src/drumGrid.sv
src/drumTop.sv
tb/drumTop_props.sv
tb/drumTb.sv

// File: Bender.yml
package:
  name: drum_membrane

sources:
  - src/drumPkg.sv
  - src/drumNode.sv
  - src/stepSequencer.sv
  - src/drumGrid.sv
  - src/drumTop.sv
  - target: test
    files:
      - tb/drumTop_props.sv
      - tb/drumTb.sv
